// ==== gpu_sched_pkg.sv ====
package gpu_sched_pkg;

	// Cluster size and task list depth
	localparam int NUM_WARPS = 8;
	localparam int TASK_DEPTH = 16;

	// Register units free after reset or clear
	localparam int REG_CAPACITY = 32;

	// Fixed part of a slot's run time
	localparam int RUN_BASE = 2;

	// Pointer address widths, without the wrap bit
	localparam int WARP_AW = $clog2(NUM_WARPS);
	localparam int TASK_AW = $clog2(TASK_DEPTH);

	// Task word layout
	localparam int TW_VALID = 28;
	localparam int TW_SW_HI = 27;
	localparam int TW_SW_LO = 20;
	localparam int TW_PC_HI = 19;
	localparam int TW_PC_LO = 11;
	localparam int TW_MASK_HI = 10;
	localparam int TW_MASK_LO = 3;
	localparam int TW_NREG_HI = 2;
	localparam int TW_NREG_LO = 0;

	typedef logic [WARP_AW-1:0] hw_warp_t;
	typedef logic [7:0] sw_warp_t;
	typedef logic [8:0] pc_t;
	typedef logic [7:0] amask_t;
	typedef logic [2:0] nreg_t;
	typedef logic [5:0] reg_count_t;
	typedef logic [28:0] task_word_t;

	// Task manager top-level states
	typedef enum logic [1:0] {
		WAITING,
		WORKING,
		COMPLETE,
		CLEARING
	} sched_state_t;

endpackage

// ==== warp_dispatch_if.sv ====
`timescale 1ns/10ps

// Four-phase dispatch link from task manager to one warp slot
interface warp_dispatch_if;
	import gpu_sched_pkg::*;

	// Handshake pair
	logic req;
	logic ack;

	// Task payload, stable while req is high
	sw_warp_t sw_id;
	pc_t pc;
	amask_t mask;
	nreg_t nreg;

	modport manager (
		output req,
		output sw_id,
		output pc,
		output mask,
		output nreg,
		input ack
	);

	modport slot (
		input req,
		input sw_id,
		input pc,
		input mask,
		input nreg,
		output ack
	);

endinterface

// ==== task_manager.sv ====
`timescale 1ns/10ps

module task_manager (
	input logic clk,
	input logic rst,
	input logic load_en,
	input gpu_sched_pkg::task_word_t load_word,
	input logic start,
	input logic clear,
	warp_dispatch_if.manager disp [gpu_sched_pkg::NUM_WARPS],
	input logic retire_valid,
	input gpu_sched_pkg::hw_warp_t retire_hw,
	output logic issue_valid,
	output gpu_sched_pkg::hw_warp_t issue_hw,
	output gpu_sched_pkg::sw_warp_t issue_sw,
	output gpu_sched_pkg::pc_t issue_pc,
	output gpu_sched_pkg::amask_t issue_mask,
	output logic finished
);
	import gpu_sched_pkg::*;

	sched_state_t state;

	// Task list FIFO, pointers carry a wrap bit
	task_word_t task_list [TASK_DEPTH];
	logic [TASK_AW:0] tl_wptr;
	logic [TASK_AW:0] tl_rptr;

	// Free hardware warp FIFO
	hw_warp_t free_fifo [NUM_WARPS];
	logic [WARP_AW:0] fw_wptr;
	logic [WARP_AW:0] fw_rptr;

	// Register budget and per-warp bookkeeping
	reg_count_t free_regs;
	nreg_t need_rec [NUM_WARPS];
	logic [NUM_WARPS-1:0] active;

	// Open dispatch handshake
	logic [NUM_WARPS-1:0] req_q;
	logic [NUM_WARPS-1:0] ack_vec;
	logic disp_open;
	logic disp_acked;
	task_word_t disp_word;
	hw_warp_t disp_hw;

	logic tl_empty;
	logic tl_full;
	logic fw_empty;
	task_word_t head_task;
	nreg_t head_need;
	hw_warp_t fw_head;
	nreg_t disp_need;
	logic fits;
	logic load_ok;
	logic disp_start;
	logic disp_ack;
	logic issue_fire;
	logic retire_fire;
	reg_count_t issue_sub;
	reg_count_t ret_add;

	assign tl_empty = (tl_wptr == tl_rptr);
	assign tl_full = (tl_wptr[TASK_AW] != tl_rptr[TASK_AW]) &&
		(tl_wptr[TASK_AW-1:0] == tl_rptr[TASK_AW-1:0]);
	assign fw_empty = (fw_wptr == fw_rptr);

	// Head of both FIFOs
	assign head_task = task_list[tl_rptr[TASK_AW-1:0]];
	assign head_need = head_task[TW_NREG_HI:TW_NREG_LO];
	assign fw_head = free_fifo[fw_rptr[WARP_AW-1:0]];
	assign fits = (reg_count_t'(head_need) <= free_regs);

	assign load_ok = (state == WAITING) && load_en && load_word[TW_VALID] && !tl_full;

	// New dispatch only when nothing is in flight
	assign disp_start = (state == WORKING) && !disp_open && !tl_empty && !fw_empty && fits;
	assign disp_ack = ack_vec[disp_hw];
	assign issue_fire = (state == WORKING) && disp_open && !disp_acked && disp_ack;
	assign retire_fire = (state == WORKING) && retire_valid;

	assign disp_need = disp_word[TW_NREG_HI:TW_NREG_LO];
	assign issue_sub = issue_fire ? reg_count_t'(disp_need) : '0;
	assign ret_add = retire_fire ? reg_count_t'(need_rec[retire_hw]) : '0;

	// Issue report mirrors the open dispatch
	assign issue_hw = disp_hw;
	assign issue_sw = disp_word[TW_SW_HI:TW_SW_LO];
	assign issue_pc = disp_word[TW_PC_HI:TW_PC_LO];
	assign issue_mask = disp_word[TW_MASK_HI:TW_MASK_LO];

	// Same payload on every link, only the requested slot looks
	for (genvar gi = 0; gi < NUM_WARPS; gi++) begin : g_link
		assign disp[gi].req = req_q[gi];
		assign disp[gi].sw_id = issue_sw;
		assign disp[gi].pc = issue_pc;
		assign disp[gi].mask = issue_mask;
		assign disp[gi].nreg = disp_need;
		assign ack_vec[gi] = disp[gi].ack;
	end

	// Storage without reset
	always_ff @(posedge clk) begin
		if (load_ok) begin
			task_list[tl_wptr[TASK_AW-1:0]] <= load_word;
		end
		// Latched together with req so data is stable first
		if (disp_start) begin
			disp_word <= head_task;
			disp_hw <= fw_head;
		end
		if (issue_fire) begin
			need_rec[disp_hw] <= disp_need;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= WAITING;
			finished <= 1'b0;
			issue_valid <= 1'b0;
			req_q <= '0;
			disp_open <= 1'b0;
			disp_acked <= 1'b0;
			tl_wptr <= '0;
			tl_rptr <= '0;
			// Free FIFO starts full with warps 0 to 7
			fw_rptr <= '0;
			fw_wptr <= {1'b1, {WARP_AW{1'b0}}};
			for (int i = 0; i < NUM_WARPS; i++) begin
				free_fifo[i] <= hw_warp_t'(i);
			end
			free_regs <= reg_count_t'(REG_CAPACITY);
			active <= '0;
		end else begin
			issue_valid <= 1'b0;
			case (state)
				WAITING: begin
					if (load_ok) begin
						tl_wptr <= tl_wptr + 1'b1;
					end
					// Clear wins over start
					if (clear) begin
						state <= CLEARING;
					end else if (start) begin
						state <= WORKING;
					end
				end
				WORKING: begin
					if (disp_start) begin
						req_q[fw_head] <= 1'b1;
						disp_open <= 1'b1;
						disp_acked <= 1'b0;
					end
					// Ack seen, drop req and commit the issue
					if (issue_fire) begin
						req_q <= '0;
						disp_acked <= 1'b1;
						issue_valid <= 1'b1;
						tl_rptr <= tl_rptr + 1'b1;
						fw_rptr <= fw_rptr + 1'b1;
						active[disp_hw] <= 1'b1;
					end
					// Handshake closes once the slot drops ack
					if (disp_open && disp_acked && !disp_ack) begin
						disp_open <= 1'b0;
					end
					if (retire_fire) begin
						free_fifo[fw_wptr[WARP_AW-1:0]] <= retire_hw;
						fw_wptr <= fw_wptr + 1'b1;
						active[retire_hw] <= 1'b0;
					end
					free_regs <= free_regs - issue_sub + ret_add;
					// All issued, all retired, nothing in flight
					if (tl_empty && (active == '0) && !disp_open) begin
						state <= COMPLETE;
						finished <= 1'b1;
					end
				end
				COMPLETE: begin
					if (clear) begin
						state <= CLEARING;
						finished <= 1'b0;
					end
				end
				default: begin
					// Restore the reset contents
					state <= WAITING;
					req_q <= '0;
					disp_open <= 1'b0;
					disp_acked <= 1'b0;
					tl_wptr <= '0;
					tl_rptr <= '0;
					fw_rptr <= '0;
					fw_wptr <= {1'b1, {WARP_AW{1'b0}}};
					for (int i = 0; i < NUM_WARPS; i++) begin
						free_fifo[i] <= hw_warp_t'(i);
					end
					free_regs <= reg_count_t'(REG_CAPACITY);
					active <= '0;
				end
			endcase
		end
	end

endmodule

// ==== warp_slot.sv ====
`timescale 1ns/10ps

module warp_slot (
	input logic clk,
	input logic rst,
	warp_dispatch_if.slot disp,
	output logic exit_req,
	output gpu_sched_pkg::sw_warp_t exit_sw,
	input logic exit_ack
);
	import gpu_sched_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		ACCEPT,
		RUN,
		EXIT
	} slot_state_t;

	slot_state_t state;

	// Cycles left until exit_req, holds up to RUN_BASE + 14
	logic [4:0] run_cnt;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= IDLE;
			disp.ack <= 1'b0;
			exit_req <= 1'b0;
			run_cnt <= '0;
		end else begin
			// Dispatch ack falls once the manager drops req
			if (disp.ack && !disp.req) begin
				disp.ack <= 1'b0;
			end
			case (state)
				IDLE: begin
					if (disp.req) begin
						disp.ack <= 1'b1;
						// Exit lands RUN_BASE + pc[3:0] edges after this one
						run_cnt <= 5'(RUN_BASE) + 5'(disp.pc[3:0]) - 5'd1;
						state <= ACCEPT;
					end
				end
				ACCEPT, RUN: begin
					// Waiting for req to fall, countdown already running
					if (state == ACCEPT && !disp.req) begin
						state <= RUN;
					end
					if (run_cnt == '0) begin
						exit_req <= 1'b1;
						state <= EXIT;
					end else begin
						run_cnt <= run_cnt - 5'd1;
					end
				end
				default: begin
					// Exit handshake
					if (exit_req && exit_ack) begin
						exit_req <= 1'b0;
					end
					if (!exit_req && !exit_ack && !disp.ack) begin
						state <= IDLE;
					end
				end
			endcase
		end
	end

	// Software ID travels with the exit
	always_ff @(posedge clk) begin
		if (state == IDLE && disp.req) begin
			exit_sw <= disp.sw_id;
		end
	end

endmodule

// ==== exit_arbiter.sv ====
`timescale 1ns/10ps

module exit_arbiter (
	input logic clk,
	input logic rst,
	input logic [gpu_sched_pkg::NUM_WARPS-1:0] exit_req,
	input gpu_sched_pkg::sw_warp_t exit_sw [gpu_sched_pkg::NUM_WARPS],
	output logic [gpu_sched_pkg::NUM_WARPS-1:0] exit_ack,
	output logic retire_valid,
	output gpu_sched_pkg::hw_warp_t retire_hw,
	output gpu_sched_pkg::sw_warp_t retire_sw
);
	import gpu_sched_pkg::*;

	// Next slot with priority
	hw_warp_t rr_ptr;
	// A granted exit is still open
	logic busy;
	logic pick_valid;
	hw_warp_t pick;

	// Search from rr_ptr, index wraps with the warp width
	always_comb begin
		hw_warp_t idx;
		pick_valid = 1'b0;
		pick = rr_ptr;
		// Walk backwards so the closest requester wins
		for (int k = NUM_WARPS - 1; k >= 0; k--) begin
			idx = rr_ptr + hw_warp_t'(k);
			if (exit_req[idx]) begin
				pick_valid = 1'b1;
				pick = idx;
			end
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rr_ptr <= '0;
			busy <= 1'b0;
			exit_ack <= '0;
			retire_valid <= 1'b0;
		end else begin
			retire_valid <= 1'b0;
			if (!busy && pick_valid) begin
				// Grant and retire in one cycle
				exit_ack[pick] <= 1'b1;
				retire_valid <= 1'b1;
				busy <= 1'b1;
				rr_ptr <= pick + 1'b1;
			end else if (busy && !exit_req[retire_hw]) begin
				// Slot dropped its req, close the handshake
				exit_ack[retire_hw] <= 1'b0;
				busy <= 1'b0;
			end
		end
	end

	// Granted slot stays in retire_hw while busy
	always_ff @(posedge clk) begin
		if (!busy && pick_valid) begin
			retire_hw <= pick;
			retire_sw <= exit_sw[pick];
		end
	end

endmodule

// ==== warp_cluster.sv ====
`timescale 1ns/10ps

module warp_cluster (
	input logic clk,
	input logic rst,
	input logic load_en,
	input gpu_sched_pkg::task_word_t load_word,
	input logic start,
	input logic clear,
	output logic issue_valid,
	output gpu_sched_pkg::hw_warp_t issue_hw,
	output gpu_sched_pkg::sw_warp_t issue_sw,
	output gpu_sched_pkg::pc_t issue_pc,
	output gpu_sched_pkg::amask_t issue_mask,
	output logic retire_valid,
	output gpu_sched_pkg::hw_warp_t retire_hw,
	output gpu_sched_pkg::sw_warp_t retire_sw,
	output logic finished
);
	import gpu_sched_pkg::*;

	// Exit path, one bit or word per slot
	logic [NUM_WARPS-1:0] exit_req;
	logic [NUM_WARPS-1:0] exit_ack;
	sw_warp_t exit_sw [NUM_WARPS];

	// One dispatch link per slot
	warp_dispatch_if disp [NUM_WARPS] ();

	task_manager u_task_manager (
		.clk (clk),
		.rst (rst),
		.load_en (load_en),
		.load_word (load_word),
		.start (start),
		.clear (clear),
		.disp (disp),
		.retire_valid (retire_valid),
		.retire_hw (retire_hw),
		.issue_valid (issue_valid),
		.issue_hw (issue_hw),
		.issue_sw (issue_sw),
		.issue_pc (issue_pc),
		.issue_mask (issue_mask),
		.finished (finished)
	);

	for (genvar gi = 0; gi < NUM_WARPS; gi++) begin : g_slot
		warp_slot u_warp_slot (
			.clk (clk),
			.rst (rst),
			.disp (disp[gi]),
			.exit_req (exit_req[gi]),
			.exit_sw (exit_sw[gi]),
			.exit_ack (exit_ack[gi])
		);
	end

	exit_arbiter u_exit_arbiter (
		.clk (clk),
		.rst (rst),
		.exit_req (exit_req),
		.exit_sw (exit_sw),
		.exit_ack (exit_ack),
		.retire_valid (retire_valid),
		.retire_hw (retire_hw),
		.retire_sw (retire_sw)
	);

endmodule

// ==== warp_cluster_props.sv ====
`timescale 1ns/10ps

module warp_cluster_props (
	input logic clk,
	input logic rst,
	input logic [gpu_sched_pkg::NUM_WARPS-1:0] req_q,
	input logic [gpu_sched_pkg::NUM_WARPS-1:0] ack_vec,
	input gpu_sched_pkg::reg_count_t free_regs,
	input gpu_sched_pkg::sched_state_t state,
	input logic finished
);
	import gpu_sched_pkg::*;

	// New req only on a link whose ack has fallen
	req_after_ack_low: assert property (@(posedge clk) disable iff (!rst)
		((req_q & ~$past(req_q) & $past(ack_vec)) == '0))
		else $error("req rose on a dispatch link while its ack was high");

	// Budget never grows past capacity
	budget_bounded: assert property (@(posedge clk) disable iff (!rst)
		(free_regs <= reg_count_t'(REG_CAPACITY)))
		else $error("free register count above capacity: %0d", free_regs);

	finished_in_complete: assert property (@(posedge clk) disable iff (!rst)
		((state != COMPLETE) |-> !finished))
		else $error("finished high outside the COMPLETE state");

endmodule

bind task_manager warp_cluster_props u_props (
	.clk (clk),
	.rst (rst),
	.req_q (req_q),
	.ack_vec (ack_vec),
	.free_regs (free_regs),
	.state (state),
	.finished (finished)
);

// ==== warp_checker.sv ====
`timescale 1ns/10ps

module warp_checker (
	input logic clk,
	input logic rst,
	input logic clear,
	input logic issue_valid,
	input gpu_sched_pkg::hw_warp_t issue_hw,
	input gpu_sched_pkg::sw_warp_t issue_sw,
	input gpu_sched_pkg::pc_t issue_pc,
	input gpu_sched_pkg::amask_t issue_mask,
	input logic retire_valid,
	input gpu_sched_pkg::hw_warp_t retire_hw,
	input gpu_sched_pkg::sw_warp_t retire_sw,
	input logic finished
);
	import gpu_sched_pkg::*;

	int mismatch_count = 0;
	int other_count = 0;

	// Expected tasks in load order, free warps in reuse order
	task_word_t exp_q [$];
	hw_warp_t free_q [$];

	// What each warp is running
	logic [NUM_WARPS-1:0] busy;
	sw_warp_t rec_sw [NUM_WARPS];
	int rec_need [NUM_WARPS];
	int earliest [NUM_WARPS];
	int in_use;
	int cycle_no;
	logic prev_finished;
	logic prev_clear;

	task automatic push_expected(input task_word_t w);
		exp_q.push_back(w);
	endtask

	// Warps 0 to 7 free, full budget
	task automatic reset_model();
		free_q.delete();
		for (int i = 0; i < NUM_WARPS; i++) begin
			free_q.push_back(hw_warp_t'(i));
		end
		busy = '0;
		in_use = 0;
	endtask

	task automatic check_field(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			mismatch_count++;
			$display("MISMATCH %s: got %h expected %h", name, got, want);
		end
	endtask

	always @(posedge clk) begin : watch
		task_word_t w;
		hw_warp_t want_hw;
		if (!rst) begin
			reset_model();
			cycle_no = 0;
			prev_finished = 1'b0;
			prev_clear = 1'b0;
		end else begin
			cycle_no++;
			// Retire first, its warp was busy before any issue here
			if (retire_valid) begin
				if (!busy[retire_hw]) begin
					other_count++;
					$display("Retire names warp %0d which is not active", retire_hw);
				end else begin
					check_field("retire_sw", retire_sw, rec_sw[retire_hw]);
					if (cycle_no < earliest[retire_hw]) begin
						other_count++;
						$display("Warp %0d retired before its run time ended", retire_hw);
					end
					busy[retire_hw] = 1'b0;
					in_use -= rec_need[retire_hw];
					free_q.push_back(retire_hw);
				end
			end
			if (issue_valid) begin
				if (exp_q.size() == 0 || free_q.size() == 0) begin
					other_count++;
					$display("Issue seen with no pending task or no free warp");
				end else begin
					w = exp_q.pop_front();
					want_hw = free_q.pop_front();
					check_field("issue_sw", issue_sw, w[TW_SW_HI:TW_SW_LO]);
					check_field("issue_pc", issue_pc, w[TW_PC_HI:TW_PC_LO]);
					check_field("issue_mask", issue_mask, w[TW_MASK_HI:TW_MASK_LO]);
					check_field("issue_hw", issue_hw, want_hw);
					if (busy[issue_hw]) begin
						other_count++;
						$display("Warp %0d issued while still active", issue_hw);
					end
					busy[issue_hw] = 1'b1;
					rec_sw[issue_hw] = w[TW_SW_HI:TW_SW_LO];
					rec_need[issue_hw] = int'(w[TW_NREG_HI:TW_NREG_LO]);
					// Exit no sooner than base plus low PC nibble
					earliest[issue_hw] = cycle_no + RUN_BASE + int'(w[TW_PC_LO+3:TW_PC_LO]);
					in_use += rec_need[issue_hw];
					if (in_use > REG_CAPACITY) begin
						other_count++;
						$display("Register budget exceeded, %0d units in use", in_use);
					end
				end
			end
			if (finished && (exp_q.size() != 0 || busy != '0)) begin
				other_count++;
				$display("Finished is high while tasks are still pending");
			end
			if (prev_finished && !prev_clear && !finished) begin
				other_count++;
				$display("Finished fell without a clear");
			end
			if (prev_finished && prev_clear && finished) begin
				other_count++;
				$display("Finished stayed high after clear");
			end
			// Clear restores the reset warp order
			if (clear) begin
				reset_model();
			end
			prev_finished = finished;
			prev_clear = clear;
		end
	end

endmodule

// ==== tb_warp_cluster.sv ====
`timescale 1ns/10ps

module tb_warp_cluster;
	import gpu_sched_pkg::*;

	localparam int NUM_BATCHES = 3;
	localparam int BATCH_LEN = 10;
	// Reset, load gaps, start and clear overhead
	localparam int MARGIN = 300;

	logic clk;
	logic rst;
	logic load_en;
	task_word_t load_word;
	logic start;
	logic clear;
	logic issue_valid;
	hw_warp_t issue_hw;
	sw_warp_t issue_sw;
	pc_t issue_pc;
	amask_t issue_mask;
	logic retire_valid;
	hw_warp_t retire_hw;
	sw_warp_t retire_sw;
	logic finished;

	// Each row holds one batch in load order
	task_word_t batch_tab [NUM_BATCHES][BATCH_LEN];
	int cycle_count;
	int timeout_limit;
	int tb_errors;
	int seed;

	warp_cluster u_dut (
		.clk (clk),
		.rst (rst),
		.load_en (load_en),
		.load_word (load_word),
		.start (start),
		.clear (clear),
		.issue_valid (issue_valid),
		.issue_hw (issue_hw),
		.issue_sw (issue_sw),
		.issue_pc (issue_pc),
		.issue_mask (issue_mask),
		.retire_valid (retire_valid),
		.retire_hw (retire_hw),
		.retire_sw (retire_sw),
		.finished (finished)
	);

	warp_checker u_checker (
		.clk (clk),
		.rst (rst),
		.clear (clear),
		.issue_valid (issue_valid),
		.issue_hw (issue_hw),
		.issue_sw (issue_sw),
		.issue_pc (issue_pc),
		.issue_mask (issue_mask),
		.retire_valid (retire_valid),
		.retire_hw (retire_hw),
		.retire_sw (retire_sw),
		.finished (finished)
	);

	// 100 ns period
	always #50 clk = ~clk;

	// Build a task word from its fields
	function automatic task_word_t make_word(input logic v, input int sw, input int pc,
		input int mask, input int nreg);
		task_word_t w;
		w = '0;
		w[TW_VALID] = v;
		w[TW_SW_HI:TW_SW_LO] = sw_warp_t'(sw);
		w[TW_PC_HI:TW_PC_LO] = pc_t'(pc);
		w[TW_MASK_HI:TW_MASK_LO] = amask_t'(mask);
		w[TW_NREG_HI:TW_NREG_LO] = nreg_t'(nreg);
		return w;
	endfunction

	task automatic fill_table();
		// Mixed batch with three dropped words, zero need and extreme PCs
		batch_tab[0][0] = make_word(1'b1, 'h10, 'h003, 'hff, 2);
		batch_tab[0][1] = make_word(1'b0, 'h11, 'h005, 'h0f, 1);
		batch_tab[0][2] = make_word(1'b1, 'h12, 'h00a, 'hf0, 3);
		batch_tab[0][3] = make_word(1'b1, 'h13, 'h100, 'h01, 1);
		batch_tab[0][4] = make_word(1'b0, 'h14, 'h00f, 'h80, 4);
		batch_tab[0][5] = make_word(1'b1, 'h15, 'h01f, 'haa, 5);
		batch_tab[0][6] = make_word(1'b1, 'h16, 'h0e7, 'h55, 0);
		batch_tab[0][7] = make_word(1'b1, 'h17, 'h1c2, 'h3c, 4);
		batch_tab[0][8] = make_word(1'b1, 'h18, 'h00d, 'h0f, 2);
		batch_tab[0][9] = make_word(1'b0, 'h19, 'h004, 'hf0, 1);
		// Large needs so dispatch stalls on the budget after four
		batch_tab[1][0] = make_word(1'b1, 'h20, 'h00f, 'hff, 7);
		batch_tab[1][1] = make_word(1'b1, 'h21, 'h01e, 'hff, 7);
		batch_tab[1][2] = make_word(1'b1, 'h22, 'h02d, 'hfe, 7);
		batch_tab[1][3] = make_word(1'b1, 'h23, 'h03c, 'h7f, 7);
		batch_tab[1][4] = make_word(1'b1, 'h24, 'h04b, 'hff, 7);
		batch_tab[1][5] = make_word(1'b0, 'h25, 'h05a, 'h00, 7);
		batch_tab[1][6] = make_word(1'b1, 'h26, 'h069, 'h0f, 6);
		batch_tab[1][7] = make_word(1'b1, 'h27, 'h078, 'hf0, 7);
		batch_tab[1][8] = make_word(1'b1, 'h28, 'h087, 'h3c, 7);
		batch_tab[1][9] = make_word(1'b1, 'h29, 'h096, 'hc3, 5);
		// Ten small tasks so retired warps are issued again
		batch_tab[2][0] = make_word(1'b1, 'h30, 'h00c, 'h01, 1);
		batch_tab[2][1] = make_word(1'b1, 'h31, 'h10b, 'h02, 1);
		batch_tab[2][2] = make_word(1'b1, 'h32, 'h04a, 'h04, 2);
		batch_tab[2][3] = make_word(1'b1, 'h33, 'h089, 'h08, 1);
		batch_tab[2][4] = make_word(1'b1, 'h34, 'h1f8, 'h10, 3);
		batch_tab[2][5] = make_word(1'b1, 'h35, 'h027, 'h20, 1);
		batch_tab[2][6] = make_word(1'b1, 'h36, 'h0a6, 'h40, 2);
		batch_tab[2][7] = make_word(1'b1, 'h37, 'h0c5, 'h80, 1);
		batch_tab[2][8] = make_word(1'b1, 'h38, 'h0d4, 'h03, 2);
		batch_tab[2][9] = make_word(1'b1, 'h39, 'h0e3, 'h0c, 1);
	endtask

	// Worst case per task is run time plus handshake slack
	function automatic int compute_limit();
		int total;
		total = MARGIN;
		for (int b = 0; b < NUM_BATCHES; b++) begin
			for (int i = 0; i < BATCH_LEN; i++) begin
				total += RUN_BASE + 15 + 20;
			end
		end
		return total;
	endfunction

	// Load one batch, start, wait for finished, then clear
	task automatic run_batch(input int b);
		int gap;
		for (int i = 0; i < BATCH_LEN; i++) begin
			gap = $urandom % 4;
			repeat (gap) @(posedge clk);
			@(posedge clk);
			load_en <= 1'b1;
			load_word <= batch_tab[b][i];
			// Only valid words are expected to issue
			if (batch_tab[b][i][TW_VALID]) begin
				u_checker.push_expected(batch_tab[b][i]);
			end
			@(posedge clk);
			load_en <= 1'b0;
		end
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		while (!finished) begin
			@(posedge clk);
		end
		// Let finished sit a few cycles before clear
		repeat (3) @(posedge clk);
		clear <= 1'b1;
		@(posedge clk);
		clear <= 1'b0;
		@(posedge clk);
	endtask

	task automatic finish_run();
		int mism;
		int other;
		mism = u_checker.mismatch_count;
		other = u_checker.other_count + tb_errors;
		$display("Mismatches: %0d, other errors: %0d", mism, other);
		if (mism == 0 && other == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	endtask

	// Cycle counter against the run limit
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= timeout_limit) begin
			tb_errors++;
			$display("Timeout after %0d cycles, batches did not complete", cycle_count);
			finish_run();
		end
	end

	initial begin
		clk = 1'b0;
		rst = 1'b0;
		load_en = 1'b0;
		load_word = '0;
		start = 1'b0;
		clear = 1'b0;
		cycle_count = 0;
		tb_errors = 0;
		seed = 83;
		void'($urandom(seed));
		fill_table();
		timeout_limit = compute_limit();
		repeat (4) @(posedge clk);
		rst <= 1'b1;
		for (int b = 0; b < NUM_BATCHES; b++) begin
			run_batch(b);
		end
		repeat (2) @(posedge clk);
		finish_run();
	end

endmodule

// ==== all.f ====
gpu_sched_pkg.sv
warp_dispatch_if.sv
task_manager.sv
warp_slot.sv
exit_arbiter.sv
warp_cluster.sv
warp_cluster_props.sv
warp_checker.sv
tb_warp_cluster.sv

// ==== Bender.yml ====
package:
  name: warp_cluster

sources:
  - gpu_sched_pkg.sv
  - warp_dispatch_if.sv
  - task_manager.sv
  - warp_slot.sv
  - exit_arbiter.sv
  - warp_cluster.sv
  - target: simulation
    files:
      - warp_cluster_props.sv
      - warp_checker.sv
      - tb_warp_cluster.sv
